// ==== design/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

	// datapath and instruction widths
	localparam int xlen = 64;
	localparam int ilen = 32;
	localparam int reg_idx_w = 5;

	// instruction field widths
	localparam int opc_w = 7;
	localparam int func3_w = 3;
	localparam int func7_w = 7;
	localparam int shamt_w = 6;

	// major opcodes
	localparam logic [opc_w-1:0] opc_op = 7'b0110011;
	localparam logic [opc_w-1:0] opc_op_32 = 7'b0111011;
	localparam logic [opc_w-1:0] opc_op_imm = 7'b0010011;
	localparam logic [opc_w-1:0] opc_op_imm_32 = 7'b0011011;
	localparam logic [opc_w-1:0] opc_load = 7'b0000011;
	localparam logic [opc_w-1:0] opc_store = 7'b0100011;
	localparam logic [opc_w-1:0] opc_branch = 7'b1100011;
	localparam logic [opc_w-1:0] opc_jal = 7'b1101111;
	localparam logic [opc_w-1:0] opc_jalr = 7'b1100111;
	localparam logic [opc_w-1:0] opc_lui = 7'b0110111;
	localparam logic [opc_w-1:0] opc_auipc = 7'b0010111;
	localparam logic [opc_w-1:0] opc_system = 7'b1110011;

	// func7 patterns for the register-register groups
	localparam logic [func7_w-1:0] func7_base = 7'b0000000;
	localparam logic [func7_w-1:0] func7_alt = 7'b0100000;
	localparam logic [func7_w-1:0] func7_muldiv = 7'b0000001;

	// the one system word that is decoded
	localparam logic [ilen-1:0] ecall_word = 32'h0000_0073;

	typedef enum logic [2:0] {
		cls_none, cls_r, cls_i, cls_s, cls_sb, cls_u, cls_uj
	} instr_class_e;

	typedef enum logic [4:0] {
		alu_none, alu_add, alu_sub, alu_sll, alu_srl, alu_sra,
		alu_xor, alu_or, alu_and, alu_less, alu_lessu, alu_equal,
		alu_neq, alu_gte, alu_gteu, alu_mul, alu_mulh, alu_mulhsu,
		alu_mulhu, alu_div, alu_divu, alu_rem, alu_remu, alu_immval,
		alu_jump
	} alu_op_e;

	typedef enum logic [1:0] {
		mem_none, mem_read, mem_write
	} mem_access_e;

	// u* sizes are the zero-extending loads
	typedef enum logic [2:0] {
		size_none, size_byte, size_half, size_word, size_double,
		size_ubyte, size_uhalf, size_uword
	} mem_size_e;

	typedef enum logic [1:0] {
		br_none, br_cond, br_uncond
	} branch_e;

	typedef struct packed {
		logic [ilen-1:0] instr;
		logic [xlen-1:0] pc;
	} fetch_t;

	typedef struct packed {
		instr_class_e cls;
		alu_op_e alu_op;
		logic reg_write;
		logic word;
		mem_access_e mem_access;
		mem_size_e mem_size;
		branch_e branch;
		logic ecall;
		logic illegal;
	} ctrl_t;

	typedef struct packed {
		logic [reg_idx_w-1:0] rd;
		logic [reg_idx_w-1:0] rs1;
		logic [reg_idx_w-1:0] rs2;
		logic [xlen-1:0] imm;
		ctrl_t ctrl;
	} decoded_t;

endpackage

`default_nettype wire

// ==== design/pipe_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_stage #(
	parameter type payload_t = logic
) (
	input  wire logic     clk,
	input  wire logic     i_arst_n,
	input  wire logic     i_valid,
	input  payload_t      i_data,
	output logic          o_valid,
	output payload_t      o_data
);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

	// payload only moves with a strobe, otherwise the last record is held
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_data <= '0;
		end else if (i_valid) begin
			o_data <= i_data;
		end
	end

	a_valid_known: assert property (
		@(posedge clk) disable iff (!i_arst_n)
		!$isunknown(o_valid)
	) else $error("pipe_stage: o_valid unknown after reset");

endmodule

`default_nettype wire

// ==== design/imm_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module imm_gen (
	input  wire logic [rv_decode_pkg::ilen-1:0] i_instr,
	input  wire logic [rv_decode_pkg::xlen-1:0] i_pc,
	input  rv_decode_pkg::ctrl_t                i_ctrl,
	output logic [rv_decode_pkg::xlen-1:0]      o_imm
);

	logic [rv_decode_pkg::xlen-1:0] imm_i;
	logic [rv_decode_pkg::xlen-1:0] imm_s;
	logic [rv_decode_pkg::xlen-1:0] imm_sb;
	logic [rv_decode_pkg::xlen-1:0] imm_u;
	logic [rv_decode_pkg::xlen-1:0] imm_uj;
	logic [rv_decode_pkg::xlen-1:0] imm_shamt;
	logic [rv_decode_pkg::xlen-1:0] imm_base;
	logic add_pc;
	logic is_shift;

	// the five formats, all sign-extended from bit 31
	assign imm_i = {{52{i_instr[31]}}, i_instr[31:20]};
	assign imm_s = {{52{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
	assign imm_sb = {{52{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
	assign imm_u = {{32{i_instr[31]}}, i_instr[31:12], 12'b0};
	assign imm_uj = {{44{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
	assign imm_shamt = {{(rv_decode_pkg::xlen - rv_decode_pkg::shamt_w){1'b0}},
		i_instr[25:20]};

	assign is_shift = (i_ctrl.alu_op == rv_decode_pkg::alu_sll) ||
		(i_ctrl.alu_op == rv_decode_pkg::alu_srl) ||
		(i_ctrl.alu_op == rv_decode_pkg::alu_sra);

	always_comb begin
		imm_base = '0;
		add_pc = 1'b0;
		case (i_ctrl.cls)
			rv_decode_pkg::cls_i: imm_base = is_shift ? imm_shamt : imm_i;
			rv_decode_pkg::cls_s: imm_base = imm_s;
			rv_decode_pkg::cls_sb: begin
				imm_base = imm_sb;
				add_pc = 1'b1;
			end
			rv_decode_pkg::cls_uj: begin
				imm_base = imm_uj;
				add_pc = 1'b1;
			end
			rv_decode_pkg::cls_u: begin
				imm_base = imm_u;
				// opcode bit 5 is clear for auipc and set for lui
				add_pc = (i_ctrl.alu_op == rv_decode_pkg::alu_immval) && !i_instr[5];
			end
			// r type, ecall and unknown words carry no immediate
			default: imm_base = '0;
		endcase
	end

	// one adder shared by all pc-relative forms
	assign o_imm = imm_base + (add_pc ? i_pc : '0);

endmodule

`default_nettype wire

// ==== design/op_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module op_decode (
	input  wire logic [rv_decode_pkg::ilen-1:0] i_instr,
	output rv_decode_pkg::ctrl_t                o_ctrl
);

	logic [rv_decode_pkg::opc_w-1:0] opcode;
	logic [rv_decode_pkg::func3_w-1:0] func3;
	logic [rv_decode_pkg::func7_w-1:0] func7;

	assign opcode = i_instr[6:0];
	assign func3 = i_instr[14:12];
	assign func7 = i_instr[31:25];

	always_comb begin
		o_ctrl = '0;
		case (opcode)
			rv_decode_pkg::opc_op: begin
				o_ctrl.cls = rv_decode_pkg::cls_r;
				o_ctrl.reg_write = 1'b1;
				if (func7 == rv_decode_pkg::func7_muldiv) begin
					case (func3)
						3'b000: o_ctrl.alu_op = rv_decode_pkg::alu_mul;
						3'b001: o_ctrl.alu_op = rv_decode_pkg::alu_mulh;
						3'b010: o_ctrl.alu_op = rv_decode_pkg::alu_mulhsu;
						3'b011: o_ctrl.alu_op = rv_decode_pkg::alu_mulhu;
						3'b100: o_ctrl.alu_op = rv_decode_pkg::alu_div;
						3'b101: o_ctrl.alu_op = rv_decode_pkg::alu_divu;
						3'b110: o_ctrl.alu_op = rv_decode_pkg::alu_rem;
						default: o_ctrl.alu_op = rv_decode_pkg::alu_remu;
					endcase
				end else if (func7 == rv_decode_pkg::func7_base) begin
					case (func3)
						3'b000: o_ctrl.alu_op = rv_decode_pkg::alu_add;
						3'b001: o_ctrl.alu_op = rv_decode_pkg::alu_sll;
						3'b010: o_ctrl.alu_op = rv_decode_pkg::alu_less;
						3'b011: o_ctrl.alu_op = rv_decode_pkg::alu_lessu;
						3'b100: o_ctrl.alu_op = rv_decode_pkg::alu_xor;
						3'b101: o_ctrl.alu_op = rv_decode_pkg::alu_srl;
						3'b110: o_ctrl.alu_op = rv_decode_pkg::alu_or;
						default: o_ctrl.alu_op = rv_decode_pkg::alu_and;
					endcase
				end else if (func7 == rv_decode_pkg::func7_alt) begin
					case (func3)
						3'b000: o_ctrl.alu_op = rv_decode_pkg::alu_sub;
						3'b101: o_ctrl.alu_op = rv_decode_pkg::alu_sra;
						default: o_ctrl.illegal = 1'b1;
					endcase
				end else begin
					o_ctrl.illegal = 1'b1;
				end
			end
			// word variants reuse the 64-bit ops with the word flag set
			rv_decode_pkg::opc_op_32: begin
				o_ctrl.cls = rv_decode_pkg::cls_r;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.word = 1'b1;
				if (func7 == rv_decode_pkg::func7_muldiv) begin
					case (func3)
						3'b000: o_ctrl.alu_op = rv_decode_pkg::alu_mul;
						3'b100: o_ctrl.alu_op = rv_decode_pkg::alu_div;
						3'b101: o_ctrl.alu_op = rv_decode_pkg::alu_divu;
						3'b110: o_ctrl.alu_op = rv_decode_pkg::alu_rem;
						3'b111: o_ctrl.alu_op = rv_decode_pkg::alu_remu;
						default: o_ctrl.illegal = 1'b1;
					endcase
				end else if (func7 == rv_decode_pkg::func7_base) begin
					case (func3)
						3'b000: o_ctrl.alu_op = rv_decode_pkg::alu_add;
						3'b001: o_ctrl.alu_op = rv_decode_pkg::alu_sll;
						3'b101: o_ctrl.alu_op = rv_decode_pkg::alu_srl;
						default: o_ctrl.illegal = 1'b1;
					endcase
				end else if (func7 == rv_decode_pkg::func7_alt) begin
					case (func3)
						3'b000: o_ctrl.alu_op = rv_decode_pkg::alu_sub;
						3'b101: o_ctrl.alu_op = rv_decode_pkg::alu_sra;
						default: o_ctrl.illegal = 1'b1;
					endcase
				end else begin
					o_ctrl.illegal = 1'b1;
				end
			end
			rv_decode_pkg::opc_op_imm: begin
				o_ctrl.cls = rv_decode_pkg::cls_i;
				o_ctrl.reg_write = 1'b1;
				case (func3)
					3'b000: o_ctrl.alu_op = rv_decode_pkg::alu_add;
					3'b010: o_ctrl.alu_op = rv_decode_pkg::alu_less;
					3'b011: o_ctrl.alu_op = rv_decode_pkg::alu_lessu;
					3'b100: o_ctrl.alu_op = rv_decode_pkg::alu_xor;
					3'b110: o_ctrl.alu_op = rv_decode_pkg::alu_or;
					3'b111: o_ctrl.alu_op = rv_decode_pkg::alu_and;
					// six-bit shamt leaves only bits 31:26 for the func code
					3'b001: begin
						if (func7[6:1] == rv_decode_pkg::func7_base[6:1]) begin
							o_ctrl.alu_op = rv_decode_pkg::alu_sll;
						end else begin
							o_ctrl.illegal = 1'b1;
						end
					end
					default: begin
						if (func7[6:1] == rv_decode_pkg::func7_base[6:1]) begin
							o_ctrl.alu_op = rv_decode_pkg::alu_srl;
						end else if (func7[6:1] == rv_decode_pkg::func7_alt[6:1]) begin
							o_ctrl.alu_op = rv_decode_pkg::alu_sra;
						end else begin
							o_ctrl.illegal = 1'b1;
						end
					end
				endcase
			end
			rv_decode_pkg::opc_op_imm_32: begin
				o_ctrl.cls = rv_decode_pkg::cls_i;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.word = 1'b1;
				case (func3)
					3'b000: o_ctrl.alu_op = rv_decode_pkg::alu_add;
					3'b001: begin
						if (func7 == rv_decode_pkg::func7_base) begin
							o_ctrl.alu_op = rv_decode_pkg::alu_sll;
						end else begin
							o_ctrl.illegal = 1'b1;
						end
					end
					3'b101: begin
						if (func7 == rv_decode_pkg::func7_base) begin
							o_ctrl.alu_op = rv_decode_pkg::alu_srl;
						end else if (func7 == rv_decode_pkg::func7_alt) begin
							o_ctrl.alu_op = rv_decode_pkg::alu_sra;
						end else begin
							o_ctrl.illegal = 1'b1;
						end
					end
					default: o_ctrl.illegal = 1'b1;
				endcase
			end
			rv_decode_pkg::opc_load: begin
				o_ctrl.cls = rv_decode_pkg::cls_i;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.alu_op = rv_decode_pkg::alu_add;
				o_ctrl.mem_access = rv_decode_pkg::mem_read;
				case (func3)
					3'b000: o_ctrl.mem_size = rv_decode_pkg::size_byte;
					3'b001: o_ctrl.mem_size = rv_decode_pkg::size_half;
					3'b010: o_ctrl.mem_size = rv_decode_pkg::size_word;
					3'b011: o_ctrl.mem_size = rv_decode_pkg::size_double;
					3'b100: o_ctrl.mem_size = rv_decode_pkg::size_ubyte;
					3'b101: o_ctrl.mem_size = rv_decode_pkg::size_uhalf;
					3'b110: o_ctrl.mem_size = rv_decode_pkg::size_uword;
					default: o_ctrl.illegal = 1'b1;
				endcase
			end
			rv_decode_pkg::opc_store: begin
				o_ctrl.cls = rv_decode_pkg::cls_s;
				o_ctrl.alu_op = rv_decode_pkg::alu_add;
				o_ctrl.mem_access = rv_decode_pkg::mem_write;
				case (func3)
					3'b000: o_ctrl.mem_size = rv_decode_pkg::size_byte;
					3'b001: o_ctrl.mem_size = rv_decode_pkg::size_half;
					3'b010: o_ctrl.mem_size = rv_decode_pkg::size_word;
					3'b011: o_ctrl.mem_size = rv_decode_pkg::size_double;
					default: o_ctrl.illegal = 1'b1;
				endcase
			end
			rv_decode_pkg::opc_branch: begin
				o_ctrl.cls = rv_decode_pkg::cls_sb;
				o_ctrl.branch = rv_decode_pkg::br_cond;
				case (func3)
					3'b000: o_ctrl.alu_op = rv_decode_pkg::alu_equal;
					3'b001: o_ctrl.alu_op = rv_decode_pkg::alu_neq;
					3'b100: o_ctrl.alu_op = rv_decode_pkg::alu_less;
					3'b101: o_ctrl.alu_op = rv_decode_pkg::alu_gte;
					3'b110: o_ctrl.alu_op = rv_decode_pkg::alu_lessu;
					3'b111: o_ctrl.alu_op = rv_decode_pkg::alu_gteu;
					default: o_ctrl.illegal = 1'b1;
				endcase
			end
			rv_decode_pkg::opc_jal: begin
				o_ctrl.cls = rv_decode_pkg::cls_uj;
				o_ctrl.alu_op = rv_decode_pkg::alu_jump;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.branch = rv_decode_pkg::br_uncond;
			end
			// jalr computes rs1 + imm for the target
			rv_decode_pkg::opc_jalr: begin
				o_ctrl.cls = rv_decode_pkg::cls_i;
				o_ctrl.alu_op = rv_decode_pkg::alu_add;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.branch = rv_decode_pkg::br_uncond;
				o_ctrl.illegal = (func3 != 3'b000);
			end
			rv_decode_pkg::opc_lui, rv_decode_pkg::opc_auipc: begin
				o_ctrl.cls = rv_decode_pkg::cls_u;
				o_ctrl.alu_op = rv_decode_pkg::alu_immval;
				o_ctrl.reg_write = 1'b1;
			end
			// only the exact ecall word is known, the rest of the system space is not
			rv_decode_pkg::opc_system: begin
				if (i_instr == rv_decode_pkg::ecall_word) begin
					o_ctrl.ecall = 1'b1;
				end else begin
					o_ctrl.illegal = 1'b1;
				end
			end
			default: o_ctrl.illegal = 1'b1;
		endcase
	end

	// checked once the decode has settled in the time step
	always_comb begin
		a_ecall_no_write: assert final (!(o_ctrl.ecall && o_ctrl.reg_write))
			else $error("op_decode: ecall with register write");
		a_mem_class: assert final (o_ctrl.mem_access == rv_decode_pkg::mem_none ||
			o_ctrl.cls == rv_decode_pkg::cls_i || o_ctrl.cls == rv_decode_pkg::cls_s)
			else $error("op_decode: memory access outside class i or s");
	end

endmodule

`default_nettype wire

// ==== design/rv_decode_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_decode_top (
	input  wire logic                clk,
	input  wire logic                i_arst_n,
	input  wire logic                i_valid,
	input  rv_decode_pkg::fetch_t    i_fetch,
	output logic                     o_valid,
	output rv_decode_pkg::decoded_t  o_dec
);

	logic fetch_valid;
	rv_decode_pkg::fetch_t fetch_q;
	rv_decode_pkg::ctrl_t ctrl;
	logic [rv_decode_pkg::xlen-1:0] imm;
	rv_decode_pkg::decoded_t dec;

	// first stage holds the raw instruction and pc
	pipe_stage #(
		.payload_t(rv_decode_pkg::fetch_t)
	) u_in_stage (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_valid  (i_valid),
		.i_data   (i_fetch),
		.o_valid  (fetch_valid),
		.o_data   (fetch_q)
	);

	op_decode u_op_decode (
		.i_instr (fetch_q.instr),
		.o_ctrl  (ctrl)
	);

	imm_gen u_imm_gen (
		.i_instr (fetch_q.instr),
		.i_pc    (fetch_q.pc),
		.i_ctrl  (ctrl),
		.o_imm   (imm)
	);

	// register indices come straight from the word, cleared for ecall
	assign dec.rd = ctrl.ecall ? '0 : fetch_q.instr[11:7];
	assign dec.rs1 = ctrl.ecall ? '0 : fetch_q.instr[19:15];
	assign dec.rs2 = ctrl.ecall ? '0 : fetch_q.instr[24:20];
	assign dec.imm = imm;
	assign dec.ctrl = ctrl;

	pipe_stage #(
		.payload_t(rv_decode_pkg::decoded_t)
	) u_out_stage (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_valid  (fetch_valid),
		.i_data   (dec),
		.o_valid  (o_valid),
		.o_data   (o_dec)
	);

endmodule

`default_nettype wire

// ==== verification/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// alu op of the register forms, from the rv64im opcode tables
function automatic rv_decode_pkg::alu_op_e reg_alu_op(
	input logic [2:0] f3,
	input logic alt,
	input logic muldiv
);
	case ({muldiv, f3})
		4'b0000: return alt ? rv_decode_pkg::alu_sub : rv_decode_pkg::alu_add;
		4'b0001: return rv_decode_pkg::alu_sll;
		4'b0010: return rv_decode_pkg::alu_less;
		4'b0011: return rv_decode_pkg::alu_lessu;
		4'b0100: return rv_decode_pkg::alu_xor;
		4'b0101: return alt ? rv_decode_pkg::alu_sra : rv_decode_pkg::alu_srl;
		4'b0110: return rv_decode_pkg::alu_or;
		4'b0111: return rv_decode_pkg::alu_and;
		4'b1000: return rv_decode_pkg::alu_mul;
		4'b1001: return rv_decode_pkg::alu_mulh;
		4'b1010: return rv_decode_pkg::alu_mulhsu;
		4'b1011: return rv_decode_pkg::alu_mulhu;
		4'b1100: return rv_decode_pkg::alu_div;
		4'b1101: return rv_decode_pkg::alu_divu;
		4'b1110: return rv_decode_pkg::alu_rem;
		default: return rv_decode_pkg::alu_remu;
	endcase
endfunction

// loads use all seven widths, stores only the four signed ones
function automatic rv_decode_pkg::mem_size_e access_size(input logic [2:0] f3);
	case (f3)
		3'd0: return rv_decode_pkg::size_byte;
		3'd1: return rv_decode_pkg::size_half;
		3'd2: return rv_decode_pkg::size_word;
		3'd3: return rv_decode_pkg::size_double;
		3'd4: return rv_decode_pkg::size_ubyte;
		3'd5: return rv_decode_pkg::size_uhalf;
		default: return rv_decode_pkg::size_uword;
	endcase
endfunction

function automatic rv_decode_pkg::decoded_t decode_model(
	input logic [31:0] instr,
	input logic [63:0] pc
);
	rv_decode_pkg::decoded_t d;
	logic [2:0] f3;
	logic shift;
	f3 = instr[14:12];
	shift = (f3 == 3'b001) || (f3 == 3'b101);
	d = '0;
	d.rd = instr[11:7];
	d.rs1 = instr[19:15];
	d.rs2 = instr[24:20];
	case (instr[6:0])
		rv_decode_pkg::opc_op, rv_decode_pkg::opc_op_32: begin
			d.ctrl.cls = rv_decode_pkg::cls_r;
			d.ctrl.alu_op = reg_alu_op(f3, instr[30], instr[25]);
		end
		rv_decode_pkg::opc_op_imm, rv_decode_pkg::opc_op_imm_32: begin
			d.ctrl.cls = rv_decode_pkg::cls_i;
			// bit 30 only selects sra among the immediate forms
			d.ctrl.alu_op = reg_alu_op(f3, shift & instr[30], 1'b0);
			d.imm = shift ? {58'b0, instr[25:20]} : 64'($signed(instr[31:20]));
		end
		rv_decode_pkg::opc_load, rv_decode_pkg::opc_store: begin
			d.ctrl.alu_op = rv_decode_pkg::alu_add;
			d.ctrl.mem_size = access_size(f3);
			if (instr[5]) begin
				d.ctrl.cls = rv_decode_pkg::cls_s;
				d.ctrl.mem_access = rv_decode_pkg::mem_write;
				d.imm = 64'($signed({instr[31:25], instr[11:7]}));
			end else begin
				d.ctrl.cls = rv_decode_pkg::cls_i;
				d.ctrl.mem_access = rv_decode_pkg::mem_read;
				d.imm = 64'($signed(instr[31:20]));
			end
		end
		rv_decode_pkg::opc_branch: begin
			d.ctrl.cls = rv_decode_pkg::cls_sb;
			d.ctrl.branch = rv_decode_pkg::br_cond;
			case (f3)
				3'd0: d.ctrl.alu_op = rv_decode_pkg::alu_equal;
				3'd1: d.ctrl.alu_op = rv_decode_pkg::alu_neq;
				3'd4: d.ctrl.alu_op = rv_decode_pkg::alu_less;
				3'd5: d.ctrl.alu_op = rv_decode_pkg::alu_gte;
				3'd6: d.ctrl.alu_op = rv_decode_pkg::alu_lessu;
				default: d.ctrl.alu_op = rv_decode_pkg::alu_gteu;
			endcase
			d.imm = 64'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0})) + pc;
		end
		rv_decode_pkg::opc_jal: begin
			d.ctrl.cls = rv_decode_pkg::cls_uj;
			d.ctrl.alu_op = rv_decode_pkg::alu_jump;
			d.ctrl.branch = rv_decode_pkg::br_uncond;
			d.imm = 64'($signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0})) + pc;
		end
		rv_decode_pkg::opc_jalr: begin
			d.ctrl.cls = rv_decode_pkg::cls_i;
			d.ctrl.alu_op = rv_decode_pkg::alu_add;
			d.ctrl.branch = rv_decode_pkg::br_uncond;
			d.imm = 64'($signed(instr[31:20]));
		end
		rv_decode_pkg::opc_lui, rv_decode_pkg::opc_auipc: begin
			d.ctrl.cls = rv_decode_pkg::cls_u;
			d.ctrl.alu_op = rv_decode_pkg::alu_immval;
			d.imm = 64'($signed({instr[31:12], 12'b0}));
			if (instr[6:0] == rv_decode_pkg::opc_auipc) begin
				d.imm = d.imm + pc;
			end
		end
		rv_decode_pkg::opc_system: begin
			if (instr == rv_decode_pkg::ecall_word) begin
				d = '0;
				d.ctrl.ecall = 1'b1;
			end else begin
				d.ctrl.illegal = 1'b1;
			end
		end
		default: d.ctrl.illegal = 1'b1;
	endcase
	d.ctrl.word = (instr[6:0] == rv_decode_pkg::opc_op_32) ||
		(instr[6:0] == rv_decode_pkg::opc_op_imm_32);
	// ecall and unknown words are class none, so they never write
	d.ctrl.reg_write = !(d.ctrl.cls inside
		{rv_decode_pkg::cls_s, rv_decode_pkg::cls_sb, rv_decode_pkg::cls_none});
	return d;
endfunction

`endif

// ==== verification/tb_rv_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_rv_decode;

	localparam int drain_limit = 100;

	logic clk = 1'b0;
	logic i_arst_n;
	logic i_valid;
	rv_decode_pkg::fetch_t i_fetch;
	logic o_valid;
	rv_decode_pkg::decoded_t o_dec;

	logic [31:0] lfsr = 32'h41e2;
	longint cyc = 0;
	int n_checked = 0;
	rv_decode_pkg::decoded_t expect_q[$];
	longint launch_q[$];

	// opcode, func3 and func7 of each legal encoding, operand bits are filled at random
	localparam logic [31:0] arith_forms [42] = '{
		32'h0000_0033, 32'h0000_1033, 32'h0000_2033, 32'h0000_3033, 32'h0000_4033,
		32'h0000_5033, 32'h0000_6033, 32'h0000_7033, 32'h4000_0033, 32'h4000_5033,
		32'h0200_0033, 32'h0200_1033, 32'h0200_2033, 32'h0200_3033, 32'h0200_4033,
		32'h0200_5033, 32'h0200_6033, 32'h0200_7033, 32'h0000_003b, 32'h0000_103b,
		32'h0000_503b, 32'h4000_003b, 32'h4000_503b, 32'h0200_003b, 32'h0200_403b,
		32'h0200_503b, 32'h0200_603b, 32'h0200_703b, 32'h0000_0013, 32'h0000_2013,
		32'h0000_3013, 32'h0000_4013, 32'h0000_6013, 32'h0000_7013, 32'h0000_1013,
		32'h0000_5013, 32'h4000_5013, 32'h0000_001b, 32'h0000_101b, 32'h0000_501b,
		32'h4000_501b, 32'h0000_0037};
	localparam logic [31:0] mem_forms [11] = '{
		32'h0000_0003, 32'h0000_1003, 32'h0000_2003, 32'h0000_3003, 32'h0000_4003,
		32'h0000_5003, 32'h0000_6003, 32'h0000_0023, 32'h0000_1023, 32'h0000_2023,
		32'h0000_3023};
	localparam logic [31:0] flow_forms [9] = '{
		32'h0000_0063, 32'h0000_1063, 32'h0000_4063, 32'h0000_5063, 32'h0000_6063,
		32'h0000_7063, 32'h0000_006f, 32'h0000_0067, 32'h0000_0017};

	`include "decode_model.svh"

	rv_decode_top u_rv_decode_top (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_valid  (i_valid),
		.i_fetch  (i_fetch),
		.o_valid  (o_valid),
		.o_dec    (o_dec)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// bits that may vary without leaving the legal encoding
	function automatic logic [31:0] fill_form(input logic [31:0] form);
		logic [31:0] mask;
		case (form[6:0])
			rv_decode_pkg::opc_op, rv_decode_pkg::opc_op_32: mask = 32'h01ff_8f80;
			rv_decode_pkg::opc_op_imm:
				mask = (form[13:12] == 2'b01) ? 32'h03ff_8f80 : 32'hffff_8f80;
			rv_decode_pkg::opc_op_imm_32:
				mask = (form[13:12] == 2'b01) ? 32'h01ff_8f80 : 32'hffff_8f80;
			rv_decode_pkg::opc_jal, rv_decode_pkg::opc_lui, rv_decode_pkg::opc_auipc:
				mask = 32'hffff_ff80;
			default: mask = 32'hffff_8f80;
		endcase
		return form | (rand_bits(32) & mask);
	endfunction

	function automatic logic [31:0] unknown_word();
		logic [31:0] w;
		w = rand_bits(32);
		while (w[6:0] inside {rv_decode_pkg::opc_op, rv_decode_pkg::opc_op_32,
			rv_decode_pkg::opc_op_imm, rv_decode_pkg::opc_op_imm_32, rv_decode_pkg::opc_load,
			rv_decode_pkg::opc_store, rv_decode_pkg::opc_branch, rv_decode_pkg::opc_jal,
			rv_decode_pkg::opc_jalr, rv_decode_pkg::opc_lui, rv_decode_pkg::opc_auipc,
			rv_decode_pkg::opc_system}) begin
			w[6:0] = rand_bits(7);
		end
		return w;
	endfunction

	task automatic send(input logic [31:0] instr, input logic [63:0] pc);
		@(posedge clk);
		i_valid <= 1'b1;
		i_fetch.instr <= instr;
		i_fetch.pc <= pc;
		expect_q.push_back(decode_model(instr, pc));
		// cyc still holds the count from before this edge
		launch_q.push_back(cyc + 1);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			i_valid <= 1'b0;
		end
	endtask

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s: got %0h, expected %0h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_record();
		rv_decode_pkg::decoded_t exp;
		longint launch;
		exp = expect_q.pop_front();
		launch = launch_q.pop_front();
		n_checked++;
		// drive edge, then one edge per stage
		compare("latency", cyc - launch, 2);
		compare("rd", o_dec.rd, exp.rd);
		compare("rs1", o_dec.rs1, exp.rs1);
		compare("rs2", o_dec.rs2, exp.rs2);
		compare("imm", o_dec.imm, exp.imm);
		compare("class", o_dec.ctrl.cls, exp.ctrl.cls);
		compare("alu_op", o_dec.ctrl.alu_op, exp.ctrl.alu_op);
		compare("reg_write", o_dec.ctrl.reg_write, exp.ctrl.reg_write);
		compare("word", o_dec.ctrl.word, exp.ctrl.word);
		compare("mem_access", o_dec.ctrl.mem_access, exp.ctrl.mem_access);
		compare("mem_size", o_dec.ctrl.mem_size, exp.ctrl.mem_size);
		compare("branch", o_dec.ctrl.branch, exp.ctrl.branch);
		compare("ecall", o_dec.ctrl.ecall, exp.ctrl.ecall);
		compare("illegal", o_dec.ctrl.illegal, exp.ctrl.illegal);
	endtask

	// outputs are settled at the falling edge
	always @(negedge clk) begin
		if ($isunknown(o_valid)) begin
			$display("o_valid is unknown at %0t", $time);
			abort_run();
		end else if (o_valid && expect_q.size() == 0) begin
			$display("o_valid high at %0t with no instruction in flight", $time);
			abort_run();
		end else if (o_valid) begin
			check_record();
		end else if (expect_q.size() != 0 && cyc > launch_q[0] + 2) begin
			$display("instruction driven in cycle %0d never reached the output", launch_q[0]);
			abort_run();
		end
	end

	initial begin
		int k;
		logic [63:0] pc;
		logic [31:0] hi;
		logic [31:0] lo;
		i_arst_n = 1'b0;
		i_valid = 1'b0;
		i_fetch = '0;
		pc = 64'h8000_0000;
		repeat (10) @(posedge clk);
		i_arst_n <= 1'b1;
		idle(5);
		for (k = 0; k < 200; k++) begin
			send(fill_form(arith_forms[rand_bits(6) % 42]), pc);
			pc = pc + 4;
		end
		idle(4);
		// four of every load and store width
		for (k = 0; k < 44; k++) begin
			send(fill_form(mem_forms[k % 11]), pc);
		end
		idle(4);
		for (k = 0; k < 100; k++) begin
			hi = rand_bits(32);
			lo = rand_bits(30);
			send(fill_form(flow_forms[rand_bits(4) % 9]), {hi, lo[29:0], 2'b00});
		end
		idle(4);
		send(rv_decode_pkg::ecall_word, pc);
		send(32'h0, pc);
		for (k = 0; k < 30; k++) begin
			send(unknown_word(), pc);
		end
		idle(4);
		// mixed burst, gaps of zero to three idle cycles
		for (k = 0; k < 100; k++) begin
			case (rand_bits(2))
				2'd0: send(fill_form(arith_forms[rand_bits(6) % 42]), pc);
				2'd1: send(fill_form(mem_forms[rand_bits(4) % 11]), pc);
				2'd2: send(fill_form(flow_forms[rand_bits(4) % 9]), pc);
				default: send(unknown_word(), pc);
			endcase
			pc = pc + 4;
			idle(rand_bits(2));
		end
		idle(1);
		for (k = 0; k < drain_limit && expect_q.size() != 0; k++) begin
			@(posedge clk);
		end
		if (expect_q.size() != 0) begin
			$display("timeout: %0d records still pending after %0d cycles",
				expect_q.size(), drain_limit);
			abort_run();
		end else begin
			$display("%0d records checked", n_checked);
			$display("** PASS **");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verification
design/rv_decode_pkg.sv
design/pipe_stage.sv
design/imm_gen.sv
design/op_decode.sv
design/rv_decode_top.sv
verification/tb_rv_decode.sv

// ==== Bender.yml ====
package:
  name: rv_decode

sources:
  - files:
      - design/rv_decode_pkg.sv
      - design/pipe_stage.sv
      - design/imm_gen.sv
      - design/op_decode.sv
      - design/rv_decode_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_rv_decode.sv
